// ==== common/usb_rx_defs.svh ====
// FIFO depth, packet length width and CRC polynomial and residual macros

`ifndef USB_RX_DEFS_SVH
`define USB_RX_DEFS_SVH

// 16 entries in the byte FIFO
`define USB_RX_FIFO_DEPTH_LOG2 4
`define USB_PKT_LEN_W 7

// CRC polynomials without the top term, and the good-packet residuals
`define USB_CRC5_POLY 5'h05
`define USB_CRC16_POLY 16'h8005
`define USB_CRC5_RESIDUAL 5'b01100
`define USB_CRC16_RESIDUAL 16'h800D

`endif

// ==== common/usb_line_pkg.sv ====
// line-level counter types and the EOP and SYNC state enums of the receiver

package usb_line_pkg;

	// DPLL phase counter, four clocks per bit
	typedef logic [1:0] dpll_cnt_t;

	// bit position in a byte and run length of ones
	typedef logic [2:0] bit_cnt_t;

	// SE0 counting toward end of packet
	typedef enum logic [2:0] {
		EOP_IDLE,
		EOP_SE0_ONE,
		EOP_SE0_TWO,
		EOP_SE0_MANY,
		EOP_WAIT_J
	} eop_state_t;

	// K-J search through the SYNC field
	typedef enum logic [2:0] {
		SYNC_IDLE,
		SYNC_K1,
		SYNC_J1,
		SYNC_K2,
		SYNC_J2,
		SYNC_K3,
		SYNC_J3,
		SYNC_K4
	} sync_state_t;

endpackage

// ==== common/usb_packet_pkg.sv ====
// byte, PID, CRC, length and FIFO entry types plus the checker state enum

`include "usb_rx_defs.svh"

package usb_packet_pkg;

	// one received byte, LSB first on the wire
	typedef logic [7:0] usb_byte_t;

	// PID nibble in [3:0], its complement in [7:4]
	typedef logic [7:0] usb_pid_t;

	// serial CRC registers
	typedef logic [4:0] crc5_t;
	typedef logic [15:0] crc16_t;

	// bytes in a packet, PID included
	typedef logic [`USB_PKT_LEN_W-1:0] pkt_len_t;

	// bit 8 marks end of packet, bits 7:0 hold a byte
	typedef logic [8:0] fifo_entry_t;

	// packet checker FSM
	typedef enum logic [1:0] {
		CHK_IDLE,
		CHK_FETCH,
		CHK_SHIFT,
		CHK_FINISH
	} chk_state_t;

endpackage

// ==== usb_rx/usb_line_rx.sv ====
// full-speed line receiver with DPLL, SYNC search, EOP detector and NRZI deserializer

`timescale 1ns/100ps

module usb_line_rx (
	input  logic                      usb_clk,
	input  logic                      rxreset,
	input  logic                      rxp,
	input  logic                      rxm,
	output usb_packet_pkg::usb_byte_t rx_data,
	output logic                      rx_valid,
	output logic                      rx_active
);

	import usb_line_pkg::*;

	// line states
	logic j;
	logic k;
	logic se0;
	logic data_valid;

	// DPLL
	logic      data_r;
	logic      transition;
	dpll_cnt_t dpll_counter;
	logic      dpll_ce;

	// state machines
	eop_state_t  eop_state;
	eop_state_t  eop_next;
	logic        eop_detected;
	sync_state_t sync_state;
	sync_state_t sync_next;
	logic        startrx;

	// deserializer
	bit_cnt_t bitcount;
	bit_cnt_t onecount;
	logic     lastrx;
	logic     rx_bit;
	logic     stuff_bit;
	logic     data_ce;

	assign j          = rxp & ~rxm;
	assign k          = ~rxp & rxm;
	assign se0        = ~rxp & ~rxm;
	assign data_valid = rxp ^ rxm;

	// ****************************************
	// DPLL
	// ****************************************

	// restart the phase on every J/K transition so the sample lands mid-bit
	assign transition = data_valid & (rxp != data_r);

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			data_r       <= 1'b1;
			dpll_counter <= '0;
			dpll_ce      <= 1'b0;
		end else begin
			if (data_valid)
				data_r <= rxp;
			if (transition)
				dpll_counter <= '0;
			else
				dpll_counter <= dpll_counter + dpll_cnt_t'(1);
			dpll_ce <= (dpll_counter == '0);
		end
	end

	// ****************************************
	// EOP detection
	// ****************************************

	always_ff @(posedge usb_clk) begin
		if (rxreset)
			eop_state <= EOP_IDLE;
		else
			eop_state <= eop_next;
	end

	// at least three SE0 clocks, then J within one more clock
	always_comb begin
		eop_next     = EOP_IDLE;
		eop_detected = 1'b0;
		unique case (eop_state)
			EOP_IDLE: begin
				if (se0)
					eop_next = EOP_SE0_ONE;
			end
			EOP_SE0_ONE: begin
				if (se0)
					eop_next = EOP_SE0_TWO;
			end
			EOP_SE0_TWO: begin
				if (se0)
					eop_next = EOP_SE0_MANY;
			end
			EOP_SE0_MANY: begin
				if (se0)
					eop_next = EOP_SE0_MANY;
				else if (j)
					eop_detected = 1'b1;
				else
					eop_next = EOP_WAIT_J;
			end
			EOP_WAIT_J: begin
				eop_detected = j;
			end
			default: eop_next = EOP_IDLE;
		endcase
	end

	// ****************************************
	// SYNC search
	// ****************************************

	always_ff @(posedge usb_clk) begin
		if (rxreset)
			sync_state <= SYNC_IDLE;
		else if (dpll_ce)
			sync_state <= sync_next;
	end

	// KJKJKJKK, the leading K may be lost while the DPLL locks
	always_comb begin
		sync_next = SYNC_IDLE;
		startrx   = 1'b0;
		unique case (sync_state)
			SYNC_IDLE: begin
				if (k & ~rx_active)
					sync_next = SYNC_K1;
			end
			SYNC_K1: if (j) sync_next = SYNC_J1;
			SYNC_J1: if (k) sync_next = SYNC_K2;
			SYNC_K2: if (j) sync_next = SYNC_J2;
			SYNC_J2: if (k) sync_next = SYNC_K3;
			SYNC_K3: begin
				if (j)
					sync_next = SYNC_J3;
				else if (k)
					startrx = 1'b1;
			end
			SYNC_J3: if (k) sync_next = SYNC_K4;
			SYNC_K4: startrx = k;
			default: sync_next = SYNC_IDLE;
		endcase
	end

	// ****************************************
	// NRZI decode and bit unstuffing
	// ****************************************

	// no line change means a one
	assign rx_bit    = j ? lastrx : ~lastrx;
	assign stuff_bit = (onecount == bit_cnt_t'(6));
	assign data_ce   = dpll_ce & rx_active & ~se0 & ~eop_detected;

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			rx_active <= 1'b0;
			rx_valid  <= 1'b0;
			bitcount  <= '0;
			onecount  <= '0;
			lastrx    <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (eop_detected) begin
				rx_active <= 1'b0;
			end else if (data_ce) begin
				if (stuff_bit) begin
					// the stuffed bit must toggle the line
					onecount <= '0;
					lastrx   <= ~lastrx;
					if (lastrx == j)
						rx_active <= 1'b0;
				end else begin
					onecount <= rx_bit ? onecount + bit_cnt_t'(1) : '0;
					lastrx   <= j;
					rx_valid <= (bitcount == bit_cnt_t'(7));
					bitcount <= bitcount + bit_cnt_t'(1);
				end
			end else if (dpll_ce & ~rx_active & startrx) begin
				// last two SYNC bits were K K, a one
				rx_active <= 1'b1;
				bitcount  <= '0;
				onecount  <= bit_cnt_t'(1);
				lastrx    <= 1'b0;
			end
		end
	end

	always_ff @(posedge usb_clk) begin
		if (data_ce & ~stuff_bit)
			rx_data <= {rx_bit, rx_data[7:1]};
	end

endmodule

// ==== source/rx_byte_fifo.sv ====
// circular byte FIFO with end-of-packet markers and sticky overflow flag

`timescale 1ns/100ps

`include "usb_rx_defs.svh"

module rx_byte_fifo (
	input  logic                        usb_clk,
	input  logic                        rxreset,
	input  usb_packet_pkg::usb_byte_t   rx_data,
	input  logic                        rx_valid,
	input  logic                        rx_active,
	input  logic                        pop,
	output usb_packet_pkg::fifo_entry_t rd_entry,
	output logic                        empty,
	output logic                        fifo_overflow
);

	import usb_packet_pkg::*;

	localparam int AW    = `USB_RX_FIFO_DEPTH_LOG2;
	localparam int DEPTH = 1 << AW;

	fifo_entry_t mem [DEPTH];

	// extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        active_q;
	logic        end_mark;
	logic        wr_req;
	logic        full;
	fifo_entry_t wr_entry;

	assign end_mark = active_q & ~rx_active;
	assign wr_req   = rx_valid | end_mark;
	assign wr_entry = end_mark ? {1'b1, 8'h00} : {1'b0, rx_data};
	assign empty    = (wr_ptr == rd_ptr);
	assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			active_q      <= 1'b0;
			fifo_overflow <= 1'b0;
		end else begin
			active_q <= rx_active;
			if (wr_req) begin
				if (full)
					fifo_overflow <= 1'b1;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop & ~empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage and registered read port
	always_ff @(posedge usb_clk) begin
		if (wr_req & ~full)
			mem[wr_ptr[AW-1:0]] <= wr_entry;
		if (pop)
			rd_entry <= mem[rd_ptr[AW-1:0]];
	end

endmodule

// ==== source/usb_packet_checker.sv ====
// packet checker FSM with PID check, serial CRC5 and CRC16 and per-packet report

`timescale 1ns/100ps

`include "usb_rx_defs.svh"

module usb_packet_checker (
	input  logic                        usb_clk,
	input  logic                        rxreset,
	input  usb_packet_pkg::fifo_entry_t rd_entry,
	input  logic                        empty,
	input  logic                        hold,
	output logic                        pop,
	output usb_packet_pkg::usb_byte_t   byte_data,
	output logic                        byte_valid,
	output logic                        pkt_done,
	output usb_packet_pkg::usb_pid_t    pkt_pid,
	output usb_packet_pkg::pkt_len_t    pkt_len,
	output logic                        pkt_pid_ok,
	output logic                        pkt_crc_ok
);

	import usb_packet_pkg::*;

	chk_state_t state;
	pkt_len_t   len;
	crc5_t      crc5;
	crc16_t     crc16;
	logic [2:0] bit_cnt;
	logic       din;
	logic       crc5_fb;
	logic       crc16_fb;
	logic       pid_ok_next;
	logic       crc_ok_next;

	assign pop = (state == CHK_IDLE) & ~empty & ~hold;

	// bytes go into the CRCs LSB first
	assign din      = byte_data[bit_cnt];
	assign crc5_fb  = crc5[4] ^ din;
	assign crc16_fb = crc16[15] ^ din;

	// ****************************************
	// packet checks
	// ****************************************

	assign pid_ok_next = (pkt_pid[3:0] == ~pkt_pid[7:4]);

	always_comb begin
		unique case (pkt_pid[1:0])
			// token
			2'b01: crc_ok_next = (len == pkt_len_t'(3)) && (crc5 == `USB_CRC5_RESIDUAL);
			// data
			2'b11: crc_ok_next = (len >= pkt_len_t'(3)) && (crc16 == `USB_CRC16_RESIDUAL);
			// handshake is the PID alone
			2'b10: crc_ok_next = (len == pkt_len_t'(1));
			default: crc_ok_next = 1'b0;
		endcase
	end

	// ****************************************
	// FSM
	// ****************************************

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			state      <= CHK_IDLE;
			len        <= '0;
			bit_cnt    <= '0;
			crc5       <= '1;
			crc16      <= '1;
			byte_valid <= 1'b0;
			pkt_done   <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			pkt_done   <= 1'b0;
			unique case (state)
				CHK_IDLE: begin
					if (pop)
						state <= CHK_FETCH;
				end
				CHK_FETCH: begin
					if (rd_entry[8]) begin
						// end marker, report and start over
						pkt_done <= 1'b1;
						len      <= '0;
						crc5     <= '1;
						crc16    <= '1;
						state    <= CHK_IDLE;
					end else begin
						bit_cnt <= '0;
						state   <= CHK_SHIFT;
					end
				end
				CHK_SHIFT: begin
					// PID byte stays out of the CRCs
					if (len != '0) begin
						crc5  <= {crc5[3:0], 1'b0} ^ (crc5_fb ? `USB_CRC5_POLY : 5'd0);
						crc16 <= {crc16[14:0], 1'b0} ^ (crc16_fb ? `USB_CRC16_POLY : 16'd0);
					end
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						byte_valid <= 1'b1;
						state      <= CHK_FINISH;
					end
				end
				CHK_FINISH: begin
					len   <= len + pkt_len_t'(1);
					state <= CHK_IDLE;
				end
				default: state <= CHK_IDLE;
			endcase
		end
	end

	// byte and result registers
	always_ff @(posedge usb_clk) begin
		if (state == CHK_FETCH) begin
			if (rd_entry[8]) begin
				pkt_len    <= len;
				pkt_pid_ok <= pid_ok_next;
				pkt_crc_ok <= crc_ok_next;
			end else begin
				byte_data <= rd_entry[7:0];
				if (len == '0)
					pkt_pid <= rd_entry[7:0];
			end
		end
	end

endmodule

// ==== source/usb_rx_top.sv ====
// receive path top with line receiver, byte FIFO and packet checker

`timescale 1ns/100ps

module usb_rx_top (
	input  logic                      usb_clk,
	input  logic                      rxreset,
	input  logic                      rxp,
	input  logic                      rxm,
	input  logic                      hold,
	output usb_packet_pkg::usb_byte_t byte_data,
	output logic                      byte_valid,
	output logic                      pkt_done,
	output usb_packet_pkg::usb_pid_t  pkt_pid,
	output usb_packet_pkg::pkt_len_t  pkt_len,
	output logic                      pkt_pid_ok,
	output logic                      pkt_crc_ok,
	output logic                      fifo_overflow,
	output logic                      rx_active
);

	import usb_packet_pkg::*;

	usb_byte_t   rx_data;
	logic        rx_valid;
	logic        pop;
	logic        empty;
	fifo_entry_t rd_entry;

	usb_line_rx i_line_rx (
		.usb_clk   (usb_clk),
		.rxreset   (rxreset),
		.rxp       (rxp),
		.rxm       (rxm),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.rx_active (rx_active)
	);

	rx_byte_fifo i_fifo (
		.usb_clk       (usb_clk),
		.rxreset       (rxreset),
		.rx_data       (rx_data),
		.rx_valid      (rx_valid),
		.rx_active     (rx_active),
		.pop           (pop),
		.rd_entry      (rd_entry),
		.empty         (empty),
		.fifo_overflow (fifo_overflow)
	);

	usb_packet_checker i_checker (
		.usb_clk    (usb_clk),
		.rxreset    (rxreset),
		.rd_entry   (rd_entry),
		.empty      (empty),
		.hold       (hold),
		.pop        (pop),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.pkt_done   (pkt_done),
		.pkt_pid    (pkt_pid),
		.pkt_len    (pkt_len),
		.pkt_pid_ok (pkt_pid_ok),
		.pkt_crc_ok (pkt_crc_ok)
	);

endmodule

// ==== sim/usb_clk_gen.sv ====
// testbench clock source with a 20 ns usb_clk and a three-cycle rxreset

`timescale 1ns/100ps

module usb_clk_gen (
	output logic usb_clk,
	output logic rxreset
);

	initial begin
		usb_clk = 1'b0;
		forever #10 usb_clk = ~usb_clk;
	end

	initial begin
		rxreset = 1'b1;
		repeat (3) @(posedge usb_clk);
		rxreset <= 1'b0;
	end

endmodule

// ==== sim/usb_rx_properties.sv ====
// concurrent assertions on the receive path, bound into the top level

`timescale 1ns/100ps

module usb_rx_properties (
	input logic usb_clk,
	input logic rxreset,
	input logic rx_valid,
	input logic rx_active,
	input logic pop,
	input logic pkt_done,
	input logic fifo_overflow
);

	// a byte strobe only inside a packet
	a_valid_in_packet: assert property (@(posedge usb_clk) disable iff (rxreset)
		rx_valid |-> rx_active)
		else $error("rx_valid high while rx_active is low");

	// one pop per fetched entry
	a_pop_one_cycle: assert property (@(posedge usb_clk) disable iff (rxreset)
		pop |=> !pop)
		else $error("pop lasted longer than one cycle");

	a_done_one_cycle: assert property (@(posedge usb_clk) disable iff (rxreset)
		pkt_done |=> !pkt_done)
		else $error("pkt_done lasted longer than one cycle");

	// overflow is sticky until reset
	a_overflow_sticky: assert property (@(posedge usb_clk) disable iff (rxreset)
		fifo_overflow |=> fifo_overflow)
		else $error("fifo_overflow cleared without rxreset");

endmodule

bind usb_rx_top usb_rx_properties i_props (
	.usb_clk       (usb_clk),
	.rxreset       (rxreset),
	.rx_valid      (rx_valid),
	.rx_active     (rx_active),
	.pop           (pop),
	.pkt_done      (pkt_done),
	.fifo_overflow (fifo_overflow)
);

// ==== sim/usb_rx_tb.sv ====
// testbench top with line driver, CRC reference model, directed tests and compare tasks

`timescale 1ns/100ps

module usb_rx_tb;

	import usb_packet_pkg::*;

	localparam int WAIT_LIMIT = 3000;

	logic        usb_clk;
	logic        rxreset;
	logic        rxp;
	logic        rxm;
	logic        hold;
	usb_byte_t   byte_data;
	logic        byte_valid;
	logic        pkt_done;
	usb_pid_t    pkt_pid;
	pkt_len_t    pkt_len;
	logic        pkt_pid_ok;
	logic        pkt_crc_ok;
	logic        fifo_overflow;
	logic        rx_active;

	// bytes of the packets in flight, PID first
	usb_byte_t tx_q[$];
	int        value_errors;
	int        timeouts;

	usb_clk_gen i_clk_gen (
		.usb_clk (usb_clk),
		.rxreset (rxreset)
	);

	usb_rx_top i_dut (
		.usb_clk       (usb_clk),
		.rxreset       (rxreset),
		.rxp           (rxp),
		.rxm           (rxm),
		.hold          (hold),
		.byte_data     (byte_data),
		.byte_valid    (byte_valid),
		.pkt_done      (pkt_done),
		.pkt_pid       (pkt_pid),
		.pkt_len       (pkt_len),
		.pkt_pid_ok    (pkt_pid_ok),
		.pkt_crc_ok    (pkt_crc_ok),
		.fifo_overflow (fifo_overflow),
		.rx_active     (rx_active)
	);

	// ****************************************
	// compare tasks
	// ****************************************

	task automatic compare_byte(input string test, input usb_byte_t exp, input usb_byte_t act);
		if (exp !== act) begin
			$display("Fail %s byte: expected %02h, actual %02h", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic compare_pid(input string test, input usb_pid_t exp, input usb_pid_t act);
		if (exp !== act) begin
			$display("Fail %s pid: expected %02h, actual %02h", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic compare_len(input string test, input pkt_len_t exp, input pkt_len_t act);
		if (exp !== act) begin
			$display("Fail %s length: expected %0d, actual %0d", test, exp, act);
			value_errors++;
		end
	endtask

	task automatic compare_flag(input string test, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %s: expected %b, actual %b", test, exp, act);
			value_errors++;
		end
	endtask

	// ****************************************
	// line driver
	// ****************************************

	// one bit time is four clocks
	task automatic drive_line(input logic p, input logic m);
		@(posedge usb_clk);
		rxp <= p;
		rxm <= m;
		repeat (3) @(posedge usb_clk);
	endtask

	// SYNC, NRZI data LSB first, stuffing after six ones, then EOP
	task automatic send_packet(input int base, input int n, input bit no_stuff);
		logic lvl;
		int   ones;
		lvl = 1'b1;
		for (int i = 0; i < 7; i++) begin
			lvl = ~lvl;
			drive_line(lvl, ~lvl);
		end
		drive_line(lvl, ~lvl);
		// the last SYNC bit is a one and counts toward stuffing
		ones = 1;
		for (int b = base; b < base + n; b++) begin
			for (int i = 0; i < 8; i++) begin
				if (tx_q[b][i]) begin
					ones++;
				end else begin
					lvl  = ~lvl;
					ones = 0;
				end
				drive_line(lvl, ~lvl);
				if (ones == 6 && !no_stuff) begin
					lvl  = ~lvl;
					ones = 0;
					drive_line(lvl, ~lvl);
				end
			end
		end
		drive_line(1'b0, 1'b0);
		drive_line(1'b0, 1'b0);
		drive_line(1'b1, 1'b0);
		repeat (4) drive_line(1'b1, 1'b0);
	endtask

	// ****************************************
	// CRC reference, USB polynomials
	// ****************************************

	// x^5 + x^2 + 1 over the 11 token bits
	function automatic crc5_t crc5_of(input logic [10:0] bits);
		crc5_t c;
		logic  fb;
		c = '1;
		for (int i = 0; i < 11; i++) begin
			fb = c[4] ^ bits[i];
			c  = {c[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
		end
		return c;
	endfunction

	// x^16 + x^15 + x^2 + 1 over queued bytes
	function automatic crc16_t crc16_of(input int base, input int n);
		crc16_t c;
		logic   fb;
		c = '1;
		for (int b = base; b < base + n; b++) begin
			for (int i = 0; i < 8; i++) begin
				fb = c[15] ^ tx_q[b][i];
				c  = {c[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
			end
		end
		return c;
	endfunction

	task automatic push_token(input logic [6:0] addr, input logic [3:0] endp, input bit corrupt);
		logic [15:0] field;
		crc5_t       c;
		field[10:0] = {endp, addr};
		c = crc5_of(field[10:0]);
		// inverted CRC goes out MSB first
		for (int i = 0; i < 5; i++)
			field[11 + i] = ~c[4 - i];
		if (corrupt)
			field[0] = ~field[0];
		tx_q.push_back(8'h69);
		tx_q.push_back(field[7:0]);
		tx_q.push_back(field[15:8]);
	endtask

	// ****************************************
	// response checks
	// ****************************************

	task automatic wait_byte(input string test, output bit seen);
		seen = 1'b0;
		for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(negedge usb_clk);
			seen = byte_valid;
		end
		if (!seen) begin
			$display("%s: no byte_valid within %0d cycles", test, WAIT_LIMIT);
			timeouts++;
		end
	endtask

	task automatic wait_done(input string test, output bit seen);
		seen = 1'b0;
		for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(negedge usb_clk);
			seen = pkt_done;
		end
		if (!seen) begin
			$display("%s: no pkt_done within %0d cycles", test, WAIT_LIMIT);
			timeouts++;
		end
	endtask

	task automatic expect_packet(input string test, input int base, input int n,
			input logic pid_ok, input logic crc_ok);
		bit seen;
		for (int i = 0; i < n; i++) begin
			wait_byte(test, seen);
			if (!seen)
				return;
			compare_byte(test, tx_q[base + i], byte_data);
		end
		wait_done(test, seen);
		if (!seen)
			return;
		compare_pid(test, tx_q[base], pkt_pid);
		compare_len(test, pkt_len_t'(n), pkt_len);
		compare_flag({test, " pid_ok"}, pid_ok, pkt_pid_ok);
		compare_flag({test, " crc_ok"}, crc_ok, pkt_crc_ok);
	endtask

	// ****************************************
	// directed tests
	// ****************************************

	task automatic run_handshake();
		tx_q.delete();
		tx_q.push_back(8'hD2);
		fork
			send_packet(0, 1, 1'b0);
			expect_packet("handshake", 0, 1, 1'b1, 1'b1);
		join
	endtask

	task automatic run_token();
		tx_q.delete();
		push_token(7'h3A, 4'h5, 1'b0);
		push_token(7'h3A, 4'h5, 1'b1);
		fork
			send_packet(0, 3, 1'b0);
			expect_packet("token", 0, 3, 1'b1, 1'b1);
		join
		fork
			send_packet(3, 3, 1'b0);
			expect_packet("token_bad_crc", 3, 3, 1'b1, 1'b0);
		join
	endtask

	task automatic run_data_stuffing();
		crc16_t      c;
		logic [31:0] r;
		logic [7:0]  b0;
		logic [7:0]  b1;
		tx_q.delete();
		tx_q.push_back(8'hC3);
		for (int i = 0; i < 4; i++) begin
			r = $urandom;
			tx_q.push_back(r[7:0]);
		end
		repeat (3) tx_q.push_back(8'hFF);
		c = crc16_of(1, 7);
		for (int i = 0; i < 8; i++) begin
			b0[i] = ~c[15 - i];
			b1[i] = ~c[7 - i];
		end
		tx_q.push_back(b0);
		tx_q.push_back(b1);
		fork
			send_packet(0, 10, 1'b0);
			expect_packet("data_stuffing", 0, 10, 1'b1, 1'b1);
		join
	endtask

	task automatic run_pid_error();
		tx_q.delete();
		tx_q.push_back(8'hC2);
		fork
			send_packet(0, 1, 1'b0);
			expect_packet("pid_error", 0, 1, 1'b0, 1'b1);
		join
	endtask

	task automatic run_back_pressure();
		tx_q.delete();
		tx_q.push_back(8'hD2);
		push_token(7'h11, 4'h2, 1'b0);
		@(posedge usb_clk);
		hold <= 1'b1;
		send_packet(0, 1, 1'b0);
		send_packet(1, 3, 1'b0);
		@(posedge usb_clk);
		hold <= 1'b0;
		expect_packet("back_pressure_ack", 0, 1, 1'b1, 1'b1);
		expect_packet("back_pressure_token", 1, 3, 1'b1, 1'b1);
		compare_flag("back_pressure overflow", 1'b0, fifo_overflow);
	endtask

	// seven ones with no stuffed bit inside the second byte
	task automatic run_stuff_error();
		tx_q.delete();
		tx_q.push_back(8'h4B);
		tx_q.push_back(8'hFF);
		fork
			send_packet(0, 2, 1'b1);
			expect_packet("stuff_error", 0, 1, 1'b1, 1'b0);
		join
		compare_flag("stuff_error rx_active", 1'b0, rx_active);
		tx_q.delete();
		tx_q.push_back(8'hD2);
		fork
			send_packet(0, 1, 1'b0);
			expect_packet("after_stuff_error", 0, 1, 1'b1, 1'b1);
		join
	endtask

	task automatic wait_reset();
		bit released;
		released = 1'b0;
		for (int n = 0; n < 20 && !released; n++) begin
			@(negedge usb_clk);
			released = !rxreset;
		end
		if (!released) begin
			$display("rxreset never went low");
			timeouts++;
		end
	endtask

	initial begin
		void'($urandom(32'h9fc3_a438));
		value_errors = 0;
		timeouts     = 0;
		rxp          = 1'b1;
		rxm          = 1'b0;
		hold         = 1'b0;
		wait_reset();
		repeat (4) drive_line(1'b1, 1'b0);
		run_handshake();
		run_token();
		run_data_stuffing();
		run_pid_error();
		run_back_pressure();
		run_stuff_error();
		$display("value errors %0d, timeouts %0d", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+common
common/usb_line_pkg.sv
common/usb_packet_pkg.sv
usb_rx/usb_line_rx.sv
source/rx_byte_fifo.sv
source/usb_packet_checker.sv
source/usb_rx_top.sv
sim/usb_clk_gen.sv
sim/usb_rx_properties.sv
sim/usb_rx_tb.sv

// ==== Makefile ====
.PHONY: all build lint clean

all: build
	./obj_dir/Vusb_rx_tb 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed!" sim.log || (echo "simulation ended early"; exit 1)

build:
	verilator --binary --assert -Wno-fatal -f sim.f --top-module usb_rx_tb -o Vusb_rx_tb

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module usb_rx_tb

clean:
	rm -rf obj_dir sim.log
